//--- hw/aud_pkg.sv
`default_nettype none

package aud_pkg;

    // one audio sample, msb first on the wire.
    localparam int unsigned SAMPLE_W = 16;

    // word address into the 1M x 16 SRAM.
    localparam int unsigned ADDR_W = 20;

    // counts the bits of one sample.
    localparam int unsigned BIT_CNT_W = 5;

    // words per recording when the top does not override it.
    localparam int unsigned MAX_WORDS_DEFAULT = 1024000;

    // recorder FSM.
    // REC_WAIT_FRAME waits for a falling edge of lrc, which marks the left word.
    // REC_FINISH lasts one cycle and raises done on its way back to idle.
    typedef enum logic [2:0] {
        REC_IDLE       = 3'd0,
        REC_WAIT_FRAME = 3'd1,
        REC_CAPTURE    = 3'd2, // shifting the 16 left bits.
        REC_PAUSE      = 3'd3,
        REC_FINISH     = 3'd4
    } rec_state_t;

endpackage

`default_nettype wire

//--- hw/rec_sample_if.sv
`timescale 1ns/10ps
`default_nettype none

// completed samples, recorder to SRAM write port.
// addr and data mean something only while valid is high.
interface rec_sample_if;
    import aud_pkg::*;

    logic                valid; // one cycle per sample.
    logic [ADDR_W-1:0]   addr;
    logic [SAMPLE_W-1:0] data;
    logic                last;  // sample that fills the recording.

    modport rec_src (
        output valid,
        output addr,
        output data,
        output last
    );

    modport sram_sink (
        input valid,
        input addr,
        input data,
        input last
    );

endinterface

`default_nettype wire

//--- hw/aud_recorder.sv
`timescale 1ns/10ps
`default_nettype none

module aud_recorder #(
    parameter int unsigned P_MAX_WORDS = aud_pkg::MAX_WORDS_DEFAULT
) (
    input  wire            i_clk,
    input  wire            i_rst_n,
    input  wire            i_lrc,
    input  wire            i_data,
    input  wire            i_start,
    input  wire            i_pause,
    input  wire            i_stop,
    output logic           o_recording,
    output logic           o_done,
    rec_sample_if.rec_src  smp
);
    import aud_pkg::*;

    localparam logic [ADDR_W-1:0]    LAST_ADDR = ADDR_W'(P_MAX_WORDS - 1);
    localparam logic [BIT_CNT_W-1:0] LAST_BIT  = BIT_CNT_W'(SAMPLE_W - 1);

    rec_state_t            state_r, state_w;
    logic [BIT_CNT_W-1:0]  bit_cnt_r, bit_cnt_w;
    logic [ADDR_W-1:0]     addr_r, addr_w;
    logic [SAMPLE_W-1:0]   shift_r;
    logic                  shift_en;
    logic                  lrc_q;
    logic                  lrc_fall;
    logic                  valid_r, valid_w;
    logic                  last_r, last_w;
    logic                  done_r, done_w;

    assign lrc_fall = lrc_q & ~i_lrc; // first cycle of the left half.

    always_comb begin
        state_w   = state_r;
        bit_cnt_w = bit_cnt_r;
        addr_w    = addr_r;
        valid_w   = 1'b0;
        last_w    = 1'b0;
        done_w    = 1'b0;
        shift_en  = 1'b0;

        // the address moves on once the sample has been handed over.
        if (valid_r) begin
            addr_w = addr_r + 1'b1;
        end

        case (state_r)
            REC_IDLE: begin
                if (i_start) begin
                    state_w = REC_WAIT_FRAME;
                    addr_w  = '0;
                end
            end

            REC_WAIT_FRAME: begin
                if (i_stop) begin
                    state_w = REC_FINISH;
                end else if (i_pause) begin
                    state_w = REC_PAUSE;
                end else if (lrc_fall) begin
                    state_w   = REC_CAPTURE; // this edge is the delay bit.
                    bit_cnt_w = '0;
                end
            end

            REC_CAPTURE: begin
                if (i_stop) begin
                    state_w = REC_FINISH;
                end else if (i_pause) begin
                    state_w = REC_PAUSE; // partial word is dropped.
                end else if (i_lrc) begin
                    // right half started early, word is incomplete.
                    state_w = REC_WAIT_FRAME;
                end else begin
                    shift_en = 1'b1;
                    if (bit_cnt_r == LAST_BIT) begin
                        valid_w = 1'b1;
                        last_w  = (addr_r == LAST_ADDR);
                        state_w = last_w ? REC_FINISH : REC_WAIT_FRAME;
                    end else begin
                        bit_cnt_w = bit_cnt_r + 1'b1;
                    end
                end
            end

            REC_PAUSE: begin
                if (i_stop) begin
                    state_w = REC_FINISH;
                end else if (i_pause) begin
                    state_w = REC_WAIT_FRAME; // resume on the next frame.
                end
            end

            REC_FINISH: begin
                done_w  = 1'b1;
                state_w = REC_IDLE;
            end

            default: begin
                state_w = REC_IDLE;
            end
        endcase
    end

    always_ff @(posedge i_clk) begin
        if (i_rst_n) begin
            state_r   <= REC_IDLE;
            bit_cnt_r <= '0;
            addr_r    <= '0;
            lrc_q     <= 1'b0;
            valid_r   <= 1'b0;
            last_r    <= 1'b0;
            done_r    <= 1'b0;
        end else begin
            state_r   <= state_w;
            bit_cnt_r <= bit_cnt_w;
            addr_r    <= addr_w;
            lrc_q     <= i_lrc;
            valid_r   <= valid_w;
            last_r    <= last_w;
            done_r    <= done_w;
        end
    end

    // msb arrives first.
    always_ff @(posedge i_clk) begin
        if (shift_en) begin
            shift_r <= {shift_r[SAMPLE_W-2:0], i_data};
        end
    end

    assign o_recording = state_r inside {REC_WAIT_FRAME, REC_CAPTURE, REC_PAUSE};
    assign o_done      = done_r;

    assign smp.valid = valid_r;
    assign smp.addr  = addr_r;
    assign smp.data  = shift_r;
    assign smp.last  = last_r;

    // a sample is preceded by a whole word of capture, first bit to last.
    a_valid_from_capture: assert property (
        @(posedge i_clk) disable iff (i_rst_n)
        valid_r |-> $past(state_r == REC_CAPTURE) &&
                    $past(state_r == REC_CAPTURE, SAMPLE_W)
    );

    a_addr_in_range: assert property (
        @(posedge i_clk) disable iff (i_rst_n)
        addr_r <= P_MAX_WORDS
    );

endmodule

`default_nettype wire

//--- hw/sram_write_port.sv
`timescale 1ns/10ps
`default_nettype none

module sram_write_port (
    input  wire                            i_clk,
    input  wire                            i_rst_n,
    rec_sample_if.sram_sink                smp,
    output logic [aud_pkg::ADDR_W-1:0]     o_sram_addr,
    output logic [aud_pkg::SAMPLE_W-1:0]   o_sram_dq,
    output logic                           o_sram_we_n,
    output logic                           o_sram_ce_n
);

    // strobes are low for the one cycle after valid.
    always_ff @(posedge i_clk) begin
        if (i_rst_n) begin
            o_sram_we_n <= 1'b1;
            o_sram_ce_n <= 1'b1;
        end else begin
            o_sram_we_n <= ~smp.valid;
            o_sram_ce_n <= ~smp.valid;
        end
    end

    // address and data are held until the next sample,
    // so they stay stable on both sides of the strobe.
    always_ff @(posedge i_clk) begin
        if (smp.valid) begin
            o_sram_addr <= smp.addr;
            o_sram_dq   <= smp.data;
        end
    end

    // samples are far apart, a write never runs into the next one.
    a_we_single_cycle: assert property (
        @(posedge i_clk) disable iff (i_rst_n)
        !o_sram_we_n |=> o_sram_we_n
    );

endmodule

`default_nettype wire

//--- hw/aud_capture_top.sv
`timescale 1ns/10ps
`default_nettype none

module aud_capture_top #(
    parameter int unsigned P_MAX_WORDS = aud_pkg::MAX_WORDS_DEFAULT
) (
    input  wire                            i_clk,
    input  wire                            i_rst_n,
    input  wire                            i_lrc,
    input  wire                            i_data,
    input  wire                            i_start,
    input  wire                            i_pause,
    input  wire                            i_stop,
    output logic [aud_pkg::ADDR_W-1:0]     o_sram_addr,
    output logic [aud_pkg::SAMPLE_W-1:0]   o_sram_dq,
    output logic                           o_sram_we_n,
    output logic                           o_sram_ce_n,
    output logic                           o_recording,
    output logic                           o_done
);

    rec_sample_if rec_smp ();

    // serial capture and key handling.
    aud_recorder #(
        .P_MAX_WORDS (P_MAX_WORDS)
    ) i_aud_recorder (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_lrc       (i_lrc),
        .i_data      (i_data),
        .i_start     (i_start),
        .i_pause     (i_pause),
        .i_stop      (i_stop),
        .o_recording (o_recording),
        .o_done      (o_done),
        .smp         (rec_smp.rec_src)
    );

    // one SRAM write per sample.
    sram_write_port i_sram_write_port (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .smp         (rec_smp.sram_sink),
        .o_sram_addr (o_sram_addr),
        .o_sram_dq   (o_sram_dq),
        .o_sram_we_n (o_sram_we_n),
        .o_sram_ce_n (o_sram_ce_n)
    );

endmodule

`default_nettype wire

//--- testbench/tb_aud_tasks.svh
`ifndef TB_AUD_TASKS_SVH
`define TB_AUD_TASKS_SVH

// galois form of x^32 + x^22 + x^2 + x + 1.
function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    if (s[0]) begin
        return (s >> 1) ^ 32'h8020_0003;
    end
    return s >> 1;
endfunction

task automatic rand_bits(input int unsigned n, output logic [31:0] value);
    value = '0;
    for (int unsigned i = 0; i < n; i++) begin
        value      = {value[30:0], lfsr_state[0]};
        lfsr_state = lfsr_step(lfsr_state);
    end
endtask

function automatic string rec_state_name();
    rec_state_t st;
    st = i_aud_capture_top.i_aud_recorder.state_r;
    return st.name();
endfunction

task automatic note_error();
    error_count = error_count + 1;
    test_errors = test_errors + 1;
endtask

task automatic check_eq(input string what, input logic [63:0] expected,
                        input logic [63:0] actual);
    if (actual !== expected) begin
        $display("mismatch %s expected %0h actual %0h (%s)", cur_test, expected, actual, what);
        note_error();
    end
endtask

task automatic begin_test(input string name);
    cur_test    = name;
    test_errors = 0;
    test_count  = test_count + 1;
    done_count  = 0;
    write_q.delete();
    expect_q.delete();
endtask

task automatic end_test();
    if (test_errors != 0) begin
        failed_tests = failed_tests + 1;
    end
    $display("test %s finished with %0d errors", cur_test, test_errors);
endtask

task automatic next_cycle();
    @(posedge clk);
    #(DRIVE_DLY);
endtask

task automatic drive_key(input key_kind_t kind, input logic on);
    start = on && (kind == KEY_START);
    pause = on && (kind == KEY_PAUSE);
    stop  = on && (kind == KEY_STOP);
endtask

task automatic pulse_key(input key_kind_t kind);
    next_cycle();
    drive_key(kind, 1'b1);
    next_cycle();
    drive_key(kind, 1'b0);
endtask

task automatic idle_cycles(input int unsigned n);
    repeat (n) begin
        next_cycle();
        lrc   = 1'b1;
        sdata = 1'b0;
        drive_key(KEY_NONE, 1'b0);
    end
endtask

// one frame, left half first; key fires in frame cycle key_at.
task automatic send_frame(input logic [SAMPLE_W-1:0] left, input key_kind_t key,
                          input int key_at);
    logic [31:0] noise;
    for (int c = 0; c < FRAME_CYCLES; c++) begin
        next_cycle();
        lrc = (c >= FRAME_CYCLES / 2);
        if (c >= 1 && c <= SAMPLE_W) begin
            sdata = left[SAMPLE_W - c];
        end else begin
            rand_bits(1, noise);
            sdata = noise[0]; // delay bit, padding and the right word.
        end
        drive_key(key, c == key_at);
    end
endtask

task automatic wait_writes(input int unsigned n, input int unsigned max_cycles);
    int unsigned waited;
    waited = 0;
    while (write_q.size() < n && waited < max_cycles) begin
        @(posedge clk);
        waited++;
    end
    if (write_q.size() < n) begin
        $display("%s: no SRAM write %0d within %0d cycles, recorder in %s",
                 cur_test, n, max_cycles, rec_state_name());
        note_error();
    end
endtask

task automatic wait_done(input int unsigned n, input int unsigned max_cycles);
    int unsigned waited;
    waited = 0;
    while (done_count < n && waited < max_cycles) begin
        @(posedge clk);
        waited++;
    end
    if (done_count < n) begin
        $display("%s: done pulse %0d did not come within %0d cycles, recorder in %s",
                 cur_test, n, max_cycles, rec_state_name());
        note_error();
    end
endtask

task automatic expect_write(input int unsigned addr, input logic [SAMPLE_W-1:0] data);
    expect_q.push_back({ADDR_W'(addr), data});
endtask

task automatic check_writes();
    check_eq("write count", expect_q.size(), write_q.size());
    for (int i = 0; i < expect_q.size() && i < write_q.size(); i++) begin
        check_eq($sformatf("write %0d addr", i), expect_q[i][ADDR_W+SAMPLE_W-1:SAMPLE_W],
                 write_q[i][ADDR_W+SAMPLE_W-1:SAMPLE_W]);
        check_eq($sformatf("write %0d data", i), expect_q[i][SAMPLE_W-1:0],
                 write_q[i][SAMPLE_W-1:0]);
    end
endtask

task automatic finish_recording(input int unsigned done_target);
    pulse_key(KEY_STOP);
    wait_done(done_target, 20);
    idle_cycles(2);
    check_eq("recording after stop", 0, recording);
endtask

task automatic test_reset_state();
    begin_test("reset_state");
    idle_cycles(2);
    check_eq("we_n", 1, sram_we_n);
    check_eq("ce_n", 1, sram_ce_n);
    check_eq("done", 0, done);
    check_eq("recording", 0, recording);
    end_test();
endtask

task automatic test_single_capture();
    begin_test("single_capture");
    pulse_key(KEY_START);
    check_eq("recording after start", 1, recording);
    send_frame(16'ha5c3, KEY_NONE, -1);
    expect_write(0, 16'ha5c3);
    wait_writes(1, 100);
    idle_cycles(4);
    check_writes();
    finish_recording(1);
    end_test();
endtask

task automatic test_streaming();
    logic [31:0] word;
    begin_test("streaming");
    pulse_key(KEY_START);
    for (int unsigned i = 0; i < 4; i++) begin
        rand_bits(SAMPLE_W, word);
        expect_write(i, word[SAMPLE_W-1:0]);
        send_frame(word[SAMPLE_W-1:0], KEY_NONE, -1);
    end
    wait_writes(4, 100);
    idle_cycles(4);
    check_writes();
    finish_recording(1);
    end_test();
endtask

task automatic test_pause_resume();
    begin_test("pause_resume");
    pulse_key(KEY_START);
    send_frame(16'h1234, KEY_NONE, -1);
    expect_write(0, 16'h1234);
    send_frame(16'hdead, KEY_PAUSE, 9); // cut off mid-word.
    check_eq("recording while paused", 1, recording);
    send_frame(16'hbeef, KEY_NONE, -1);
    send_frame(16'hcafe, KEY_NONE, -1);
    check_eq("writes while paused", 1, write_q.size());
    check_eq("recording still paused", 1, recording);
    pulse_key(KEY_PAUSE);
    send_frame(16'h5a5a, KEY_NONE, -1);
    expect_write(1, 16'h5a5a);
    wait_writes(2, 100);
    idle_cycles(4);
    check_writes();
    finish_recording(1);
    end_test();
endtask

task automatic test_stop();
    begin_test("stop");
    pulse_key(KEY_START);
    send_frame(16'h0f0f, KEY_NONE, -1);
    send_frame(16'hf0f0, KEY_NONE, -1);
    expect_write(0, 16'h0f0f);
    expect_write(1, 16'hf0f0);
    send_frame(16'h7777, KEY_STOP, 8);
    wait_done(1, 20);
    send_frame(16'h1111, KEY_NONE, -1);
    send_frame(16'h2222, KEY_NONE, -1);
    check_eq("done pulses", 1, done_count);
    check_eq("recording after stop", 0, recording);
    check_writes();
    // a new recording starts over at address 0.
    write_q.delete();
    expect_q.delete();
    pulse_key(KEY_START);
    send_frame(16'h4321, KEY_NONE, -1);
    expect_write(0, 16'h4321);
    wait_writes(1, 100);
    check_writes();
    finish_recording(2);
    end_test();
endtask

task automatic test_limit();
    logic [31:0] word;
    begin_test("limit");
    pulse_key(KEY_START);
    for (int unsigned i = 0; i < MAX_WORDS + 2; i++) begin
        rand_bits(SAMPLE_W, word);
        if (i < MAX_WORDS) begin
            expect_write(i, word[SAMPLE_W-1:0]);
        end
        send_frame(word[SAMPLE_W-1:0], KEY_NONE, -1);
    end
    wait_done(1, 100);
    idle_cycles(4);
    check_writes();
    check_eq("done pulses", 1, done_count);
    check_eq("recording at limit", 0, recording);
    end_test();
endtask

`endif

//--- testbench/tb_aud_capture.sv
`timescale 1ns/10ps
`default_nettype none

module tb_aud_capture;
    import aud_pkg::*;

    localparam int unsigned MAX_WORDS = 6;
    localparam int unsigned CLK_PERIOD = 100;
    localparam int unsigned DRIVE_DLY = 10;
    localparam int unsigned FRAME_CYCLES = 64;

    typedef enum logic [1:0] {
        KEY_NONE,
        KEY_START,
        KEY_PAUSE,
        KEY_STOP
    } key_kind_t;

    logic                clk;
    logic                rst_n;
    logic                lrc;
    logic                sdata;
    logic                start;
    logic                pause;
    logic                stop;
    logic [ADDR_W-1:0]   sram_addr;
    logic [SAMPLE_W-1:0] sram_dq;
    logic                sram_we_n;
    logic                sram_ce_n;
    logic                recording;
    logic                done;

    // writes seen on the SRAM bus and writes the test predicts, {addr, data}.
    logic [ADDR_W+SAMPLE_W-1:0] write_q[$];
    logic [ADDR_W+SAMPLE_W-1:0] expect_q[$];

    int unsigned done_count;
    int unsigned error_count;
    int unsigned test_errors;
    int unsigned test_count;
    int unsigned failed_tests;
    string       cur_test;
    logic [31:0] lfsr_state;

    aud_capture_top #(
        .P_MAX_WORDS (MAX_WORDS)
    ) i_aud_capture_top (
        .i_clk       (clk),
        .i_rst_n     (rst_n),
        .i_lrc       (lrc),
        .i_data      (sdata),
        .i_start     (start),
        .i_pause     (pause),
        .i_stop      (stop),
        .o_sram_addr (sram_addr),
        .o_sram_dq   (sram_dq),
        .o_sram_we_n (sram_we_n),
        .o_sram_ce_n (sram_ce_n),
        .o_recording (recording),
        .o_done      (done)
    );

    `include "tb_aud_tasks.svh"

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // bus sampled mid-cycle, well away from the rising edge.
    always @(negedge clk) begin
        if (sram_we_n === 1'b0) begin
            write_q.push_back({sram_addr, sram_dq});
        end
        if (sram_we_n !== sram_ce_n) begin
            $display("%s: chip enable and write enable differ on the SRAM bus", cur_test);
            note_error();
        end
        if (done === 1'b1) begin
            done_count = done_count + 1;
        end
    end

    initial begin
        rst_n        = 1'b1; // reset is active high.
        lrc          = 1'b1;
        sdata        = 1'b0;
        start        = 1'b0;
        pause        = 1'b0;
        stop         = 1'b0;
        done_count   = 0;
        error_count  = 0;
        test_errors  = 0;
        test_count   = 0;
        failed_tests = 0;
        cur_test     = "reset";
        lfsr_state   = 32'h67cdb3ff;

        repeat (5) @(posedge clk);
        #(DRIVE_DLY);
        rst_n = 1'b0;

        test_reset_state();
        test_single_capture();
        test_streaming();
        test_pause_resume();
        test_stop();
        test_limit();

        $display("tests %0d, failed %0d, errors %0d", test_count, failed_tests, error_count);
        if (error_count == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- sources.f
+incdir+testbench
hw/aud_pkg.sv
hw/rec_sample_if.sv
hw/aud_recorder.sv
hw/sram_write_port.sv
hw/aud_capture_top.sv
testbench/tb_aud_capture.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the audio capture testbench with Verilator.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_aud_capture \
    -f sources.f \
    --Mdir obj_dir -o tb_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tb_sim > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -q "^STATUS: PASS$" "$LOG"; then
    exit 0
fi
echo "pass line not found in $LOG"
exit 1
